// ==== bench/bus_responder.sv ====
`timescale 1ns/100ps

module bus_responder #(
    parameter int resp_delay = 1
) (
    input  logic clk,
    input  logic rstn,
    input  logic stall,
    input  logic bus_wvalid,
    input  logic bus_wlast,
    input  logic bus_bready,
    output logic bus_waddr_ok,
    output logic bus_wready,
    output logic bus_bvalid
);

    logic [3:0] gap_cnt;
    logic       aw_taken;
    logic       go;
    logic       beat;

    // Address and beats are taken after a fixed gap and never while stalled
    assign go           = bus_wvalid && !stall && (gap_cnt == 4'(resp_delay));
    assign bus_waddr_ok = go && !aw_taken;
    assign bus_wready   = go;
    assign beat         = bus_wvalid && bus_wready && (aw_taken || bus_waddr_ok);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            gap_cnt    <= '0;
            aw_taken   <= 1'b0;
            bus_bvalid <= 1'b0;
        end else begin
            if (beat) begin
                gap_cnt <= '0;
            end else if (bus_wvalid && !stall && (gap_cnt != 4'(resp_delay))) begin
                gap_cnt <= gap_cnt + 1'b1;
            end
            if (beat && bus_wlast) begin
                aw_taken <= 1'b0;
            end else if (bus_waddr_ok) begin
                aw_taken <= 1'b1;
            end
            // Response follows the final beat
            if (beat && bus_wlast) begin
                bus_bvalid <= 1'b1;
            end else if (bus_bvalid && bus_bready) begin
                bus_bvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== bench/tb_l2_write_path.sv ====
`timescale 1ns/100ps

module tb_l2_write_path
    import l2_write_pkg::*;
();

    localparam int offset_width = 2;
    localparam int buf_depth    = 2;
    localparam int words        = 1 << offset_width;
    localparam int line_w       = words * word_w;
    localparam logic [addr_w-1:0] line_mask = ~(addr_w'(words * strb_w) - addr_w'(1));

    logic              clk = 1'b0;
    logic              rstn;
    logic              stall;
    logic              cache_req_w;
    logic [addr_w-1:0] cache_addr;
    logic [line_w-1:0] cache_line;
    logic              cache_dma;
    logic [strb_w-1:0] cache_wstrb;
    logic              cache_addr_ok;
    logic [addr_w-1:0] bus_waddr;
    logic [len_w-1:0]  bus_len;
    logic [strb_w-1:0] bus_wstrb;
    logic              bus_wvalid;
    logic [word_w-1:0] bus_wdata;
    logic              bus_wlast;
    logic              bus_bready;
    logic              bus_waddr_ok;
    logic              bus_wready;
    logic              bus_bvalid;

    // Bursts seen on the bus, and what the cache writes predict
    logic [addr_w-1:0] mon_addr [$];
    logic [len_w-1:0]  mon_len [$];
    logic [strb_w-1:0] mon_strb [$];
    logic [word_w-1:0] mon_data [$];
    logic              mon_last [$];
    int                mon_resp_before [$];
    int                mon_resp = 0;
    logic [addr_w-1:0] exp_addr [$];
    logic [len_w-1:0]  exp_len [$];
    logic [strb_w-1:0] exp_strb [$];
    logic [word_w-1:0] exp_data [$];
    logic              exp_last [$];
    logic [31:0]       lcg_state = 32'd92029;

    always #4 clk = ~clk;

    l2_write_path #(
        .offset_width (offset_width),
        .buf_depth    (buf_depth)
    ) l2_write_path_inst (
        .clk           (clk),
        .rstn          (rstn),
        .cache_req_w   (cache_req_w),
        .cache_addr    (cache_addr),
        .cache_line    (cache_line),
        .cache_dma     (cache_dma),
        .cache_wstrb   (cache_wstrb),
        .cache_addr_ok (cache_addr_ok),
        .bus_waddr     (bus_waddr),
        .bus_len       (bus_len),
        .bus_wstrb     (bus_wstrb),
        .bus_wvalid    (bus_wvalid),
        .bus_wdata     (bus_wdata),
        .bus_wlast     (bus_wlast),
        .bus_bready    (bus_bready),
        .bus_waddr_ok  (bus_waddr_ok),
        .bus_wready    (bus_wready),
        .bus_bvalid    (bus_bvalid)
    );

    bus_responder #(
        .resp_delay (1)
    ) bus_responder_inst (
        .clk          (clk),
        .rstn         (rstn),
        .stall        (stall),
        .bus_wvalid   (bus_wvalid),
        .bus_wlast    (bus_wlast),
        .bus_bready   (bus_bready),
        .bus_waddr_ok (bus_waddr_ok),
        .bus_wready   (bus_wready),
        .bus_bvalid   (bus_bvalid)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [line_w-1:0] make_line();
        logic [line_w-1:0] line;
        line = '0;
        for (int i = 0; i < words; i++) begin
            line[i*word_w +: word_w] = lcg_next();
        end
        return line;
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected 0x%0h actual 0x%0h", what, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out: %s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // Samples at the falling edge, when bus levels are settled
    task automatic monitor_bus();
        logic aw_open;
        aw_open = 1'b0;
        forever begin
            @(negedge clk);
            if (bus_wvalid && bus_waddr_ok && !aw_open) begin
                mon_addr.push_back(bus_waddr);
                mon_len.push_back(bus_len);
                mon_strb.push_back(bus_wstrb);
                mon_resp_before.push_back(mon_resp);
            end
            if (bus_wvalid && bus_wready && (aw_open || bus_waddr_ok)) begin
                mon_data.push_back(bus_wdata);
                mon_last.push_back(bus_wlast);
                aw_open = !bus_wlast;
            end else if (bus_wvalid && bus_waddr_ok) begin
                aw_open = 1'b1;
            end
            if (bus_bvalid && bus_bready) begin
                mon_resp = mon_resp + 1;
            end
        end
    endtask

    task automatic add_line_burst(input logic [addr_w-1:0] addr, input logic [line_w-1:0] line);
        exp_addr.push_back(addr & line_mask);
        exp_len.push_back(len_w'(words - 1));
        exp_strb.push_back({strb_w{1'b1}});
        for (int i = 0; i < words; i++) begin
            exp_data.push_back(line[i*word_w +: word_w]);
            exp_last.push_back(i == words - 1);
        end
    endtask

    task automatic record_uncached_beat(input logic [addr_w-1:0] addr,
                                        input logic [strb_w-1:0] strb,
                                        input logic [line_w-1:0] line);
        exp_addr.push_back(addr);
        exp_len.push_back(len_w'(0));
        exp_strb.push_back(strb);
        exp_data.push_back(line[word_w-1:0]);
        exp_last.push_back(1'b1);
    endtask

    task automatic drive_request(input logic [addr_w-1:0] addr, input logic [line_w-1:0] line,
                                 input logic dma, input logic [strb_w-1:0] strb);
        @(posedge clk);
        cache_req_w <= 1'b1;
        cache_addr  <= addr;
        cache_line  <= line;
        cache_dma   <= dma;
        cache_wstrb <= strb;
    endtask

    task automatic wait_accept(input string name, input logic is_dma);
        logic seen;
        logic beat_done;
        logic resp_seen;
        seen      = 1'b0;
        beat_done = 1'b0;
        resp_seen = 1'b0;
        for (int i = 0; i < 300 && !seen; i++) begin
            @(negedge clk);
            if (bus_bvalid && bus_bready && beat_done) begin
                resp_seen = 1'b1;
            end
            if (bus_wvalid && bus_wready && bus_wlast && (bus_len == '0)) begin
                beat_done = 1'b1;
            end
            if (cache_addr_ok) begin
                seen = 1'b1;
                if (is_dma) begin
                    check_value({name, " ack after response"}, 64'd1, 64'(resp_seen));
                end
            end
        end
        if (!seen) begin
            report_timeout({name, " never got cache_addr_ok"});
        end
        @(posedge clk);
        cache_req_w <= 1'b0;
    endtask

    task automatic wait_responses(input string name, input int target);
        for (int i = 0; i < 500 && mon_resp < target; i++) begin
            @(posedge clk);
        end
        if (mon_resp < target) begin
            report_timeout({name, " bus responses missing"});
        end
    endtask

    task automatic drain_and_compare(input string name, input int target);
        wait_responses(name, target);
        repeat (10) @(posedge clk);
        check_value({name, " responses"}, 64'(target), 64'(mon_resp));
        check_value({name, " burst count"}, 64'(exp_addr.size()), 64'(mon_addr.size()));
        check_value({name, " beat count"}, 64'(exp_data.size()), 64'(mon_data.size()));
        while (exp_addr.size() > 0) begin
            check_value({name, " address"}, 64'(exp_addr.pop_front()), 64'(mon_addr.pop_front()));
            check_value({name, " len"}, 64'(exp_len.pop_front()), 64'(mon_len.pop_front()));
            check_value({name, " strobe"}, 64'(exp_strb.pop_front()), 64'(mon_strb.pop_front()));
        end
        while (exp_data.size() > 0) begin
            check_value({name, " data"}, 64'(exp_data.pop_front()), 64'(mon_data.pop_front()));
            check_value({name, " wlast"}, 64'(exp_last.pop_front()), 64'(mon_last.pop_front()));
        end
        mon_resp_before.delete();
    endtask

    task automatic write_line(input string name, input logic [addr_w-1:0] addr,
                              input logic [line_w-1:0] line);
        drive_request(addr, line, 1'b0, {strb_w{1'b1}});
        wait_accept(name, 1'b0);
    endtask

    task automatic reset_values();
        @(negedge clk);
        check_value("reset bus_wvalid", 64'd0, 64'(bus_wvalid));
        check_value("reset bus_bready", 64'd0, 64'(bus_bready));
        check_value("reset cache_addr_ok", 64'd0, 64'(cache_addr_ok));
    endtask

    task automatic line_write();
        logic [line_w-1:0] line;
        int                base;
        base = mon_resp;
        line = make_line();
        add_line_burst(32'h0000_1234, line);
        write_line("line_write", 32'h0000_1234, line);
        drain_and_compare("line_write", base + 1);
    endtask

    task automatic uncached_write();
        logic [line_w-1:0] line;
        int                base;
        base = mon_resp;
        line = make_line();
        record_uncached_beat(32'h0000_2008, 4'b0110, line);
        drive_request(32'h0000_2008, line, 1'b1, 4'b0110);
        wait_accept("uncached_write", 1'b1);
        drain_and_compare("uncached_write", base + 1);
    endtask

    task automatic back_pressure();
        logic [line_w-1:0] line;
        logic [addr_w-1:0] addr;
        int                base;
        base = mon_resp;
        @(posedge clk);
        stall <= 1'b1;
        for (int i = 0; i < buf_depth; i++) begin
            addr = 32'h0001_0000 + 32'(i) * 32'h40;
            line = make_line();
            add_line_burst(addr, line);
            write_line("back_pressure", addr, line);
        end
        addr = 32'h0001_0f00;
        line = make_line();
        add_line_burst(addr, line);
        drive_request(addr, line, 1'b0, {strb_w{1'b1}});
        // Buffer is full and the head burst is stuck
        repeat (20) begin
            @(negedge clk);
            check_value("back_pressure held ack", 64'd0, 64'(cache_addr_ok));
        end
        @(posedge clk);
        stall <= 1'b0;
        wait_accept("back_pressure", 1'b0);
        drain_and_compare("back_pressure", base + buf_depth + 1);
    endtask

    task automatic coalescing();
        logic [line_w-1:0] line_a;
        logic [line_w-1:0] line_b;
        int                base;
        base   = mon_resp;
        line_a = make_line();
        @(posedge clk);
        stall <= 1'b1;
        add_line_burst(32'h0002_0000, line_a);
        write_line("coalescing", 32'h0002_0000, line_a);
        write_line("coalescing", 32'h0002_0080, make_line());
        // Second write to line B lands on another word of the same line
        line_b = make_line();
        add_line_burst(32'h0002_0080, line_b);
        write_line("coalescing", 32'h0002_0084, line_b);
        repeat (5) @(posedge clk);
        stall <= 1'b0;
        drain_and_compare("coalescing", base + 2);
    endtask

    task automatic write_ordering();
        logic [line_w-1:0] line_c;
        logic [line_w-1:0] line_d;
        logic [line_w-1:0] line_e;
        int                base;
        base   = mon_resp;
        line_c = make_line();
        line_d = make_line();
        line_e = make_line();
        add_line_burst(32'h0003_0000, line_c);
        add_line_burst(32'h0003_0040, line_d);
        record_uncached_beat(32'h0003_0104, 4'b0011, line_e);
        write_line("write_ordering", 32'h0003_0000, line_c);
        write_line("write_ordering", 32'h0003_0040, line_d);
        drive_request(32'h0003_0104, line_e, 1'b1, 4'b0011);
        wait_accept("write_ordering", 1'b1);
        wait_responses("write_ordering", base + 3);
        repeat (10) @(posedge clk);
        check_value("write_ordering responses before beat", 64'(base + 2),
                    64'(mon_resp_before[2]));
        drain_and_compare("write_ordering", base + 3);
    endtask

    initial begin
        monitor_bus();
    end

    initial begin
        rstn        = 1'b0;
        stall       = 1'b0;
        cache_req_w = 1'b0;
        cache_addr  = '0;
        cache_line  = '0;
        cache_dma   = 1'b0;
        cache_wstrb = '0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        reset_values();
        line_write();
        uncached_write();
        back_pressure();
        coalescing();
        write_ordering();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== logic/burst_writer.sv ====
`timescale 1ns/100ps

module burst_writer
    import l2_write_pkg::*;
#(
    parameter int offset_width = 2
) (
    input  logic                                  clk,
    input  logic                                  rstn,
    // Buffer head
    input  logic                                  head_valid,
    input  logic [addr_w-1:0]                     head_addr,
    input  logic [(1 << offset_width)*word_w-1:0] head_line,
    output logic                                  head_pop,
    // Bus, through the arbiter
    output logic [addr_w-1:0]                     bw_waddr,
    output logic [len_w-1:0]                      bw_len,
    output logic [strb_w-1:0]                     bw_wstrb,
    output logic                                  bw_wvalid,
    output logic [word_w-1:0]                     bw_wdata,
    output logic                                  bw_wlast,
    output logic                                  bw_bready,
    input  logic                                  bw_waddr_ok,
    input  logic                                  bw_wready,
    input  logic                                  bw_bvalid
);

    localparam int words = 1 << offset_width;
    localparam int cnt_w = (offset_width > 0) ? offset_width : 1;
    localparam logic [cnt_w-1:0] last_beat = cnt_w'(words - 1);

    logic [cnt_w-1:0] beat_cnt;
    logic             aw_done;
    logic             beat_fire;
    logic             is_last;

    assign is_last = (beat_cnt == last_beat);

    // A beat may move from the address acceptance cycle onward
    assign beat_fire = bw_wvalid && bw_wready && (aw_done || bw_waddr_ok);

    assign bw_waddr = head_addr;
    assign bw_len   = len_w'(words - 1);
    assign bw_wstrb = '1;
    assign bw_wdata = head_line[beat_cnt*word_w +: word_w];
    assign bw_wlast = bw_wvalid && is_last;
    assign head_pop = bw_bready && bw_bvalid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bw_wvalid <= 1'b0;
            bw_bready <= 1'b0;
            beat_cnt  <= '0;
            aw_done   <= 1'b0;
        end else begin
            if (!bw_wvalid && !bw_bready) begin
                // Idle writer starts on any pending head entry
                if (head_valid) begin
                    bw_wvalid <= 1'b1;
                    beat_cnt  <= '0;
                    aw_done   <= 1'b0;
                end
            end else if (bw_wvalid) begin
                if (bw_waddr_ok) begin
                    aw_done <= 1'b1;
                end
                if (beat_fire) begin
                    if (is_last) begin
                        bw_wvalid <= 1'b0;
                        bw_bready <= 1'b1;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
            end else if (bw_bvalid) begin
                // The head leaves the buffer on this response
                bw_bready <= 1'b0;
                aw_done   <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/l2_write_path.sv ====
`timescale 1ns/100ps

module l2_write_path
    import l2_write_pkg::*;
#(
    parameter int offset_width = 2,
    parameter int buf_depth    = 2
) (
    input  logic                                  clk,
    input  logic                                  rstn,
    // Cache write port
    input  logic                                  cache_req_w,
    input  logic [addr_w-1:0]                     cache_addr,
    input  logic [(1 << offset_width)*word_w-1:0] cache_line,
    input  logic                                  cache_dma,
    input  logic [strb_w-1:0]                     cache_wstrb,
    output logic                                  cache_addr_ok,
    // Memory write bus
    output logic [addr_w-1:0]                     bus_waddr,
    output logic [len_w-1:0]                      bus_len,
    output logic [strb_w-1:0]                     bus_wstrb,
    output logic                                  bus_wvalid,
    output logic [word_w-1:0]                     bus_wdata,
    output logic                                  bus_wlast,
    output logic                                  bus_bready,
    input  logic                                  bus_waddr_ok,
    input  logic                                  bus_wready,
    input  logic                                  bus_bvalid
);

    localparam int line_w = (1 << offset_width) * word_w;

    logic              buf_req;
    logic [addr_w-1:0] buf_addr;
    logic [line_w-1:0] buf_line;
    logic              buf_accept;
    logic              drained;

    logic              head_valid;
    logic [addr_w-1:0] head_addr;
    logic [line_w-1:0] head_line;
    logic              head_pop;

    logic [addr_w-1:0] bw_waddr;
    logic [len_w-1:0]  bw_len;
    logic [strb_w-1:0] bw_wstrb;
    logic              bw_wvalid;
    logic [word_w-1:0] bw_wdata;
    logic              bw_wlast;
    logic              bw_bready;
    logic              bw_waddr_ok;
    logic              bw_wready;
    logic              bw_bvalid;

    write_arbiter #(
        .offset_width (offset_width)
    ) write_arbiter_inst (
        .clk           (clk),
        .rstn          (rstn),
        .cache_req_w   (cache_req_w),
        .cache_addr    (cache_addr),
        .cache_line    (cache_line),
        .cache_dma     (cache_dma),
        .cache_wstrb   (cache_wstrb),
        .cache_addr_ok (cache_addr_ok),
        .buf_req       (buf_req),
        .buf_addr      (buf_addr),
        .buf_line      (buf_line),
        .buf_accept    (buf_accept),
        .drained       (drained),
        .bw_waddr      (bw_waddr),
        .bw_len        (bw_len),
        .bw_wstrb      (bw_wstrb),
        .bw_wvalid     (bw_wvalid),
        .bw_wdata      (bw_wdata),
        .bw_wlast      (bw_wlast),
        .bw_bready     (bw_bready),
        .bw_waddr_ok   (bw_waddr_ok),
        .bw_wready     (bw_wready),
        .bw_bvalid     (bw_bvalid),
        .bus_waddr     (bus_waddr),
        .bus_len       (bus_len),
        .bus_wstrb     (bus_wstrb),
        .bus_wvalid    (bus_wvalid),
        .bus_wdata     (bus_wdata),
        .bus_wlast     (bus_wlast),
        .bus_bready    (bus_bready),
        .bus_waddr_ok  (bus_waddr_ok),
        .bus_wready    (bus_wready),
        .bus_bvalid    (bus_bvalid)
    );

    write_buffer #(
        .offset_width (offset_width),
        .buf_depth    (buf_depth)
    ) write_buffer_inst (
        .clk        (clk),
        .rstn       (rstn),
        .buf_req    (buf_req),
        .buf_addr   (buf_addr),
        .buf_line   (buf_line),
        .buf_accept (buf_accept),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_line  (head_line),
        .head_pop   (head_pop),
        .drained    (drained)
    );

    burst_writer #(
        .offset_width (offset_width)
    ) burst_writer_inst (
        .clk         (clk),
        .rstn        (rstn),
        .head_valid  (head_valid),
        .head_addr   (head_addr),
        .head_line   (head_line),
        .head_pop    (head_pop),
        .bw_waddr    (bw_waddr),
        .bw_len      (bw_len),
        .bw_wstrb    (bw_wstrb),
        .bw_wvalid   (bw_wvalid),
        .bw_wdata    (bw_wdata),
        .bw_wlast    (bw_wlast),
        .bw_bready   (bw_bready),
        .bw_waddr_ok (bw_waddr_ok),
        .bw_wready   (bw_wready),
        .bw_bvalid   (bw_bvalid)
    );

endmodule

// ==== logic/l2_write_pkg.sv ====
package l2_write_pkg;

    // Memory write bus geometry
    localparam int addr_w = 32;
    localparam int word_w = 32;
    localparam int strb_w = word_w / 8;

    // Burst length field carries beats minus one
    localparam int len_w = 8;

    // Write arbiter bus ownership
    // The burst writer owns the bus in st_idle and st_buf_req
    // An uncached beat is in flight in st_dma_w and its response awaited in st_dma_b
    typedef enum logic [1:0] {
        st_idle,
        st_buf_req,
        st_dma_w,
        st_dma_b
    } arb_state_t;

endpackage

// ==== logic/write_arbiter.sv ====
`timescale 1ns/100ps

module write_arbiter
    import l2_write_pkg::*;
#(
    parameter int offset_width = 2
) (
    input  logic                                  clk,
    input  logic                                  rstn,
    // Cache side
    input  logic                                  cache_req_w,
    input  logic [addr_w-1:0]                     cache_addr,
    input  logic [(1 << offset_width)*word_w-1:0] cache_line,
    input  logic                                  cache_dma,
    input  logic [strb_w-1:0]                     cache_wstrb,
    output logic                                  cache_addr_ok,
    // Write buffer side
    output logic                                  buf_req,
    output logic [addr_w-1:0]                     buf_addr,
    output logic [(1 << offset_width)*word_w-1:0] buf_line,
    input  logic                                  buf_accept,
    input  logic                                  drained,
    // Burst writer side
    input  logic [addr_w-1:0]                     bw_waddr,
    input  logic [len_w-1:0]                      bw_len,
    input  logic [strb_w-1:0]                     bw_wstrb,
    input  logic                                  bw_wvalid,
    input  logic [word_w-1:0]                     bw_wdata,
    input  logic                                  bw_wlast,
    input  logic                                  bw_bready,
    output logic                                  bw_waddr_ok,
    output logic                                  bw_wready,
    output logic                                  bw_bvalid,
    // Memory write bus
    output logic [addr_w-1:0]                     bus_waddr,
    output logic [len_w-1:0]                      bus_len,
    output logic [strb_w-1:0]                     bus_wstrb,
    output logic                                  bus_wvalid,
    output logic [word_w-1:0]                     bus_wdata,
    output logic                                  bus_wlast,
    output logic                                  bus_bready,
    input  logic                                  bus_waddr_ok,
    input  logic                                  bus_wready,
    input  logic                                  bus_bvalid
);

    arb_state_t state;
    arb_state_t state_nxt;
    logic       dma_aw_done;
    logic       dma_beat;

    // Single uncached beat goes through once the address is (or was) taken
    assign dma_beat = (state == st_dma_w) && bus_wready && (dma_aw_done || bus_waddr_ok);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dma_aw_done <= 1'b0;
        end else if (state != st_dma_w) begin
            dma_aw_done <= 1'b0;
        end else if (bus_waddr_ok) begin
            dma_aw_done <= 1'b1;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (cache_req_w) begin
                    if (!cache_dma) begin
                        state_nxt = st_buf_req;
                    end else if (drained) begin
                        // Uncached write waits for every buffered line to reach memory
                        state_nxt = st_dma_w;
                    end
                end
            end
            st_buf_req: begin
                if (buf_accept) begin
                    state_nxt = st_idle;
                end
            end
            st_dma_w: begin
                if (dma_beat) begin
                    state_nxt = st_dma_b;
                end
            end
            st_dma_b: begin
                if (bus_bvalid) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // Line payload always follows the cache and only the request is qualified
    assign buf_addr = cache_addr;
    assign buf_line = cache_line;

    always_comb begin
        cache_addr_ok = 1'b0;
        buf_req       = 1'b0;

        // Burst writer owns the bus by default
        bus_waddr   = bw_waddr;
        bus_len     = bw_len;
        bus_wstrb   = bw_wstrb;
        bus_wvalid  = bw_wvalid;
        bus_wdata   = bw_wdata;
        bus_wlast   = bw_wlast;
        bus_bready  = bw_bready;
        bw_waddr_ok = bus_waddr_ok;
        bw_wready   = bus_wready;
        bw_bvalid   = bus_bvalid;

        case (state)
            st_buf_req: begin
                buf_req       = 1'b1;
                cache_addr_ok = buf_accept;
            end
            st_dma_w: begin
                bus_waddr   = cache_addr;
                bus_len     = '0;
                bus_wstrb   = cache_wstrb;
                bus_wvalid  = 1'b1;
                bus_wdata   = cache_line[word_w-1:0];
                bus_wlast   = 1'b1;
                bus_bready  = 1'b0;
                bw_waddr_ok = 1'b0;
                bw_wready   = 1'b0;
                bw_bvalid   = 1'b0;
            end
            st_dma_b: begin
                bus_waddr     = cache_addr;
                bus_len       = '0;
                bus_wstrb     = cache_wstrb;
                bus_wvalid    = 1'b0;
                bus_wdata     = cache_line[word_w-1:0];
                bus_wlast     = 1'b0;
                bus_bready    = 1'b1;
                bw_waddr_ok   = 1'b0;
                bw_wready     = 1'b0;
                bw_bvalid     = 1'b0;
                // The uncached write is acknowledged to the cache only on its response
                cache_addr_ok = bus_bvalid;
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/write_buffer.sv ====
`timescale 1ns/100ps

module write_buffer
    import l2_write_pkg::*;
#(
    parameter int offset_width = 2,
    parameter int buf_depth    = 2
) (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  buf_req,
    input  logic [addr_w-1:0]                     buf_addr,
    input  logic [(1 << offset_width)*word_w-1:0] buf_line,
    output logic                                  buf_accept,
    output logic                                  head_valid,
    output logic [addr_w-1:0]                     head_addr,
    output logic [(1 << offset_width)*word_w-1:0] head_line,
    input  logic                                  head_pop,
    output logic                                  drained
);

    localparam int line_w = (1 << offset_width) * word_w;
    localparam int ptr_w  = (buf_depth > 1) ? $clog2(buf_depth) : 1;
    localparam int off_lsb = offset_width + $clog2(strb_w);
    localparam logic [addr_w-1:0] line_mask = ~((addr_w'(1) << off_lsb) - addr_w'(1));

    logic [addr_w-1:0] entry_addr [buf_depth];
    logic [line_w-1:0] entry_line [buf_depth];
    logic [buf_depth-1:0] used;
    logic [ptr_w-1:0]  head_ptr;
    logic [ptr_w-1:0]  tail_ptr;
    logic [addr_w-1:0] line_addr;
    logic              full;
    logic              match_hit;
    logic [ptr_w-1:0]  match_idx;
    logic              merge_en;
    logic              push_en;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(buf_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign line_addr = buf_addr & line_mask;
    assign full      = &used;
    assign drained   = ~|used;

    // Find a pending non-head entry of the same line since the head may be on the bus
    always_comb begin
        match_hit = 1'b0;
        match_idx = '0;
        for (int i = 0; i < buf_depth; i++) begin
            if (used[i] && (ptr_w'(i) != head_ptr) && (entry_addr[i] == line_addr)) begin
                match_hit = 1'b1;
                match_idx = ptr_w'(i);
            end
        end
    end

    assign buf_accept = buf_req && (match_hit || !full);
    assign merge_en   = buf_req && match_hit;
    assign push_en    = buf_req && !match_hit && !full;

    assign head_valid = used[head_ptr];
    assign head_addr  = entry_addr[head_ptr];
    assign head_line  = entry_line[head_ptr];

    always_ff @(posedge clk) begin
        if (merge_en) begin
            entry_line[match_idx] <= buf_line;
        end else if (push_en) begin
            entry_addr[tail_ptr] <= line_addr;
            entry_line[tail_ptr] <= buf_line;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            used     <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (push_en) begin
                used[tail_ptr] <= 1'b1;
                tail_ptr       <= ptr_inc(tail_ptr);
            end
            // Head and tail never coincide when both happen since full blocks the push
            if (head_pop && head_valid) begin
                used[head_ptr] <= 1'b0;
                head_ptr       <= ptr_inc(head_ptr);
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f verilog.f --top-module tb_l2_write_path -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== verilog.f ====
logic/l2_write_pkg.sv
logic/write_arbiter.sv
logic/write_buffer.sv
logic/burst_writer.sv
logic/l2_write_path.sv
bench/bus_responder.sv
bench/tb_l2_write_path.sv
